// File: sim.f
+incdir+source
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_lsu.sv
source/rv_core.sv
test/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/rv_decoder.sv
      - source/rv_alu.sv
      - source/rv_regfile.sv
      - source/rv_lsu.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/rv_core_tb.sv

// File: test/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int QUIET_CYCLES   = 16;
    localparam int PROG_WORDS     = 256;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam logic [31:0] TX_ADDR   = `RV_UART_TX_ADDR;
    localparam logic [31:0] SELF_LOOP = 32'h0000_006f;

    // x31 holds the transmit address and x29 is scratch for shifted sends
    localparam logic [4:0] X_TX  = 5'd31;
    localparam logic [4:0] X_TMP = 5'd29;

    logic             clk;
    logic             reset;
    logic [31:0]      imem_data;
    logic [31:0]      imem_addr;
    rv_pkg::uart_tx_t uart;

    logic [31:0] prog [0:PROG_WORDS-1];
    int          prog_len;
    logic [7:0]  expected_bytes [$];
    logic [7:0]  got_bytes [$];
    logic [31:0] rng_state;
    int          errors;
    int          checks;

    rv_core rv_core_inst (
        .clk         (clk),
        .reset       (reset),
        .i_imem_data (imem_data),
        .o_imem_addr (imem_addr),
        .o_uart      (uart)
    );

    // misaligned fetches and fetches past the end of the program spin in place
    assign imem_data = (imem_addr[1:0] == 2'b00 && imem_addr[31:2] < prog_len)
                       ? prog[imem_addr[9:2]] : SELF_LOOP;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // expected results straight from the RV32I definitions
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic model_branch(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic emit(input logic [31:0] inst);
        prog[prog_len] = inst;
        prog_len++;
    endtask

    // lui plus addi where the +0x800 absorbs the sign of the low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] rounded;
        rounded = value + 32'h800;
        emit(u_type(rounded[31:12], rd, OP_LUI));
        emit(i_type(value[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic send(input logic [4:0] rs);
        emit(s_type(12'h000, rs, X_TX, 3'b000));
    endtask

    task automatic send_shifted(input logic [4:0] rs, input logic [4:0] amount);
        emit(i_type({7'b0, amount}, rs, 3'b101, X_TMP, OP_IMM));
        send(X_TMP);
    endtask

    // core stays in reset while the new program is written
    task automatic start_program();
        @(negedge clk);
        reset = 1'b1;
        prog_len = 0;
        expected_bytes.delete();
        got_bytes.delete();
        emit(u_type(TX_ADDR[31:12], X_TX, OP_LUI));
    endtask

    task automatic release_reset();
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic collect_bytes(input int count, input string name);
        int cycles;
        cycles = 0;
        while (got_bytes.size() < count && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (uart.en) begin
                got_bytes.push_back(uart.data);
            end
        end
        checks++;
        assert (got_bytes.size() >= count) else begin
            errors++;
            $display("%0t: test %s timed out after %0d cycles with %0d of %0d bytes received",
                $time, name, cycles, got_bytes.size(), count);
        end
    endtask

    task automatic check_quiet(input string name);
        int extra;
        extra = 0;
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (uart.en) begin
                extra++;
            end
        end
        checks++;
        assert (extra == 0) else begin
            errors++;
            $display("%0t: test %s sent %0d bytes after its expected sequence",
                $time, name, extra);
        end
    endtask

    task automatic compare_bytes(input string name);
        checks++;
        assert (got_bytes.size() == expected_bytes.size()) else begin
            errors++;
            $display("Mismatch at %0t: o_uart byte count in %s: expected %0d, got %0d",
                $time, name, expected_bytes.size(), got_bytes.size());
        end
        for (int i = 0; i < expected_bytes.size() && i < got_bytes.size(); i++) begin
            checks++;
            assert (got_bytes[i] == expected_bytes[i]) else begin
                errors++;
                $display("Mismatch at %0t: o_uart.data byte %0d in %s: expected %02h, got %02h",
                    $time, i, name, expected_bytes[i], got_bytes[i]);
            end
        end
    endtask

    task automatic run_program(input string name);
        emit(j_type(21'd0, 5'd0));
        release_reset();
        collect_bytes(expected_bytes.size(), name);
        check_quiet(name);
        compare_bytes(name);
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm_ext;
        logic        alt;
        logic [2:0]  reg_f3 [0:9];
        logic        reg_alt [0:9];
        logic [2:0]  imm_f3 [0:8];
        logic [11:0] imm_val [0:8];
        a = 32'h9abc_def1;
        b = 32'h1234_567c;
        reg_f3  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        reg_alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        imm_f3  = '{3'd0, 3'd4, 3'd6, 3'd7, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
        imm_val = '{12'hff9, 12'h5a5, 12'h0f0, 12'h7c3, 12'h800, 12'hfff,
                    12'h003, 12'h01c, 12'h41c};
        start_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(r_type(reg_alt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, reg_f3[k], 5'd3));
            send(5'd3);
            res = model_alu(reg_f3[k], reg_alt[k], a, b);
            expected_bytes.push_back(res[7:0]);
        end
        // slt and sltu with the operands swapped
        for (int k = 2; k < 4; k++) begin
            emit(r_type(7'h00, 5'd1, 5'd2, k, 5'd3));
            send(5'd3);
            res = model_alu(k, 1'b0, b, a);
            expected_bytes.push_back(res[7:0]);
        end
        for (int k = 0; k < 9; k++) begin
            imm_ext = {{20{imm_val[k][11]}}, imm_val[k]};
            alt = (imm_f3[k] == 3'd5) && imm_val[k][10];
            emit(i_type(imm_val[k], 5'd1, imm_f3[k], 5'd3, OP_IMM));
            send(5'd3);
            res = model_alu(imm_f3[k], alt, a, imm_ext);
            expected_bytes.push_back(res[7:0]);
        end
        run_program("alu");
    endtask

    task automatic test_branches();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] lhs_val;
        logic [31:0] rhs_val;
        logic [7:0]  taken_marker;
        logic [7:0]  skip_marker;
        logic [2:0]  kinds [0:5];
        logic [4:0]  lhs [0:2];
        logic [4:0]  rhs [0:2];
        a = 32'hffff_fffd;
        b = 32'h0000_0005;
        kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        lhs   = '{5'd1, 5'd2, 5'd1};
        rhs   = '{5'd2, 5'd1, 5'd1};
        start_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                taken_marker = 8'h40 + k * 3 + p;
                skip_marker  = 8'h80 + k * 3 + p;
                // fall-through path sends skip_marker and taken path sends taken_marker
                emit(b_type(13'd16, rhs[p], lhs[p], kinds[k]));
                emit(i_type({4'h0, skip_marker}, 5'd0, 3'b000, 5'd5, OP_IMM));
                send(5'd5);
                emit(j_type(21'd12, 5'd0));
                emit(i_type({4'h0, taken_marker}, 5'd0, 3'b000, 5'd5, OP_IMM));
                send(5'd5);
                lhs_val = (lhs[p] == 5'd1) ? a : b;
                rhs_val = (rhs[p] == 5'd1) ? a : b;
                if (model_branch(kinds[k], lhs_val, rhs_val)) begin
                    expected_bytes.push_back(taken_marker);
                end else begin
                    expected_bytes.push_back(skip_marker);
                end
            end
        end
        run_program("branches");
    endtask

    // every load value goes out as its low byte and its top byte
    task automatic load_and_send(input logic [11:0] offset, input logic [2:0] f3,
            input logic [31:0] value);
        emit(i_type(offset, 5'd10, f3, 5'd12, OP_LOAD));
        send(5'd12);
        send_shifted(5'd12, 5'd24);
        expected_bytes.push_back(value[7:0]);
        expected_bytes.push_back(value[31:24]);
    endtask

    task automatic test_memory();
        logic [31:0] word;
        logic [31:0] byte_src;
        logic [31:0] half_src;
        logic [31:0] merged;
        logic [7:0]  lane_byte;
        logic [15:0] half;
        word     = 32'h80f1_7f82;
        byte_src = 32'hdead_be5a;
        half_src = 32'h7777_c3a6;
        start_program();
        emit(i_type(12'h100, 5'd0, 3'b000, 5'd10, OP_IMM));
        load_const(5'd11, word);
        emit(s_type(12'h000, 5'd11, 5'd10, 3'b010));
        for (int lane = 0; lane < 4; lane++) begin
            lane_byte = word[lane*8 +: 8];
            load_and_send(lane, 3'b000, {{24{lane_byte[7]}}, lane_byte});
            load_and_send(lane, 3'b100, {24'h0, lane_byte});
        end
        for (int off = 0; off < 4; off += 2) begin
            half = word[off*8 +: 16];
            load_and_send(off, 3'b001, {{16{half[15]}}, half});
            load_and_send(off, 3'b101, {16'h0, half});
        end
        load_and_send(12'h000, 3'b010, word);
        // sb into lane 1 and sh into the upper half leave lane 0 alone
        load_const(5'd14, byte_src);
        load_const(5'd15, half_src);
        emit(s_type(12'h001, 5'd14, 5'd10, 3'b000));
        emit(s_type(12'h002, 5'd15, 5'd10, 3'b001));
        emit(i_type(12'h000, 5'd10, 3'b010, 5'd12, OP_LOAD));
        send(5'd12);
        send_shifted(5'd12, 5'd8);
        send_shifted(5'd12, 5'd16);
        send_shifted(5'd12, 5'd24);
        merged = word;
        merged[15:8]  = byte_src[7:0];
        merged[31:16] = half_src[15:0];
        for (int lane = 0; lane < 4; lane++) begin
            expected_bytes.push_back(merged[lane*8 +: 8]);
        end
        run_program("memory");
    endtask

    task automatic test_jumps();
        logic [31:0] v;
        logic [31:0] pc_auipc;
        logic [31:0] pc_jal;
        logic [31:0] pc_jalr;
        logic [31:0] base;
        start_program();
        emit(u_type(20'habcde, 5'd5, OP_LUI));
        send_shifted(5'd5, 5'd12);
        send_shifted(5'd5, 5'd24);
        v = {20'habcde, 12'h000};
        expected_bytes.push_back(v[19:12]);
        expected_bytes.push_back(v[31:24]);
        pc_auipc = prog_len * 4;
        emit(u_type(20'h00001, 5'd6, OP_AUIPC));
        send(5'd6);
        send_shifted(5'd6, 5'd8);
        v = pc_auipc + 32'h1000;
        expected_bytes.push_back(v[7:0]);
        expected_bytes.push_back(v[15:8]);
        // the skipped pair would send 0xee
        pc_jal = prog_len * 4;
        emit(j_type(21'd12, 5'd7));
        emit(i_type(12'h0ee, 5'd0, 3'b000, 5'd8, OP_IMM));
        send(5'd8);
        send(5'd7);
        v = pc_jal + 4;
        expected_bytes.push_back(v[7:0]);
        // base + 3 is odd so the core must drop bit 0 and land on pc_jalr + 16
        pc_jalr = prog_len * 4;
        base = pc_jalr + 16 - 2;
        emit(i_type(base[11:0], 5'd0, 3'b000, 5'd9, OP_IMM));
        emit(i_type(12'h003, 5'd9, 3'b000, 5'd20, OP_JALR));
        emit(i_type(12'h0ee, 5'd0, 3'b000, 5'd8, OP_IMM));
        send(5'd8);
        send(5'd20);
        v = pc_jalr + 8;
        expected_bytes.push_back(v[7:0]);
        run_program("jumps");
    endtask

    task automatic test_zero_and_reset();
        start_program();
        emit(u_type(20'hfffff, 5'd0, OP_LUI));
        emit(i_type(12'h055, 5'd0, 3'b000, 5'd0, OP_IMM));
        emit(i_type(12'h077, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        send(5'd0);
        for (int m = 1; m < 4; m++) begin
            emit(i_type(m * 12'h011, 5'd0, 3'b000, 5'd5, OP_IMM));
            send(5'd5);
        end
        emit(j_type(21'd0, 5'd0));
        expected_bytes = '{8'h00, 8'h11, 8'h00, 8'h11, 8'h22, 8'h33};
        release_reset();
        collect_bytes(2, "zero_reset");
        // restart halfway so the whole sequence comes again
        reset = 1'b1;
        release_reset();
        collect_bytes(6, "zero_reset");
        check_quiet("zero_reset");
        compare_bytes("zero_reset");
    endtask

    task automatic test_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        start_program();
        for (int r = 0; r < 6; r++) begin
            rng_state = xorshift32(rng_state);
            a = rng_state;
            rng_state = xorshift32(rng_state);
            b = rng_state;
            load_const(5'd1, a);
            load_const(5'd2, b);
            emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
            send(5'd3);
            emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
            send(5'd3);
            emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
            send(5'd3);
            v = a + b;
            expected_bytes.push_back(v[7:0]);
            v = a - b;
            expected_bytes.push_back(v[7:0]);
            v = a ^ b;
            expected_bytes.push_back(v[7:0]);
        end
        run_program("random");
    endtask

    initial begin
        reset = 1'b1;
        prog_len = 0;
        errors = 0;
        checks = 0;
        rng_state = 32'h3ffa9d57;
        test_alu();
        test_branches();
        test_memory();
        test_jumps();
        test_zero_and_reset();
        test_random();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [`RV_XLEN-1:0] i_imem_data,
    output logic [`RV_XLEN-1:0]      o_imem_addr,
    output rv_pkg::uart_tx_t         o_uart
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;

    rv_pkg::ctrl_t    ctrl;
    rv_pkg::ctrl_t    mem_ctrl;
    rv_pkg::uart_tx_t lsu_uart;

    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] wb_data;
    logic                branch_taken;

    assign o_imem_addr = pc;
    assign pc_plus4    = pc + 32'd4;
    assign pc_target   = pc + ctrl.imm;

    rv_decoder rv_decoder_inst (
        .i_inst (i_imem_data),
        .o_ctrl (ctrl)
    );

    rv_regfile rv_regfile_inst (
        .clk        (clk),
        .i_rs1_addr (ctrl.rs1),
        .i_rs2_addr (ctrl.rs2),
        .i_rd_addr  (ctrl.rd),
        .i_write    (ctrl.reg_write && !reset),
        .i_rd_data  (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    assign alu_a = ctrl.a_is_pc ? pc : rs1_data;
    assign alu_b = ctrl.b_is_imm ? ctrl.imm : rs2_data;

    rv_alu rv_alu_inst (
        .i_op           (ctrl.alu_op),
        .i_branch       (ctrl.branch),
        .i_a            (alu_a),
        .i_b            (alu_b),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    // no stores while reset holds the core at the first fetch
    always_comb begin
        mem_ctrl       = ctrl;
        mem_ctrl.store = ctrl.store && !reset;
    end

    rv_lsu rv_lsu_inst (
        .clk          (clk),
        .i_ctrl       (mem_ctrl),
        .i_addr       (alu_result),
        .i_store_data (rs2_data),
        .o_load_data  (load_data),
        .o_uart       (lsu_uart)
    );

    always_comb begin
        if (ctrl.load) begin
            wb_data = load_data;
        end else if (ctrl.jal || ctrl.jalr) begin
            wb_data = pc_plus4;
        end else begin
            wb_data = alu_result;
        end
    end

    // jalr target is rs1 + imm with bit 0 cleared
    always_comb begin
        if (ctrl.jalr) begin
            next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
        end else if (ctrl.jal || branch_taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= `RV_RESET_PC;
            o_uart.en <= 1'b0;
        end else begin
            pc        <= next_pc;
            o_uart.en <= lsu_uart.en;
        end
        o_uart.data <= lsu_uart.data;
    end

endmodule

`default_nettype wire

// File: source/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_lsu (
    input  wire logic                clk,
    input  wire rv_pkg::ctrl_t       i_ctrl,
    input  wire logic [`RV_XLEN-1:0] i_addr,
    input  wire logic [`RV_XLEN-1:0] i_store_data,
    output logic [`RV_XLEN-1:0]      o_load_data,
    output rv_pkg::uart_tx_t         o_uart
);

    logic [`RV_XLEN-1:0] mem [0:`RV_DMEM_WORDS-1];

    logic [`RV_DMEM_ADDR_BITS-1:0] word_idx;
    logic [3:0]                    byte_en;
    logic [`RV_XLEN-1:0]           store_word;
    logic [`RV_XLEN-1:0]           rd_shifted;
    logic                          uart_hit;
    logic                          mem_write;

    assign word_idx = i_addr[`RV_DMEM_ADDR_BITS+1:2];

    // byte stores to the transmit address never reach memory
    assign uart_hit  = i_ctrl.store && (i_ctrl.mem_size == rv_pkg::MEM_BYTE)
                       && (i_addr == `RV_UART_TX_ADDR);
    assign mem_write = i_ctrl.store && !uart_hit;

    assign o_uart.en   = uart_hit;
    assign o_uart.data = i_store_data[7:0];

    // replicate the store data so every lane sees it, byte_en picks the lanes
    always_comb begin
        case (i_ctrl.mem_size)
            rv_pkg::MEM_BYTE: begin
                store_word = {4{i_store_data[7:0]}};
                byte_en    = 4'b0001 << i_addr[1:0];
            end
            rv_pkg::MEM_HALF: begin
                store_word = {2{i_store_data[15:0]}};
                byte_en    = 4'b0011 << {i_addr[1], 1'b0};
            end
            default: begin
                store_word = i_store_data;
                byte_en    = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= store_word[lane*8 +: 8];
                end
            end
        end
    end

    // addressed lane moved down to bit 0
    assign rd_shifted = mem[word_idx] >> {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_ctrl.mem_size)
            rv_pkg::MEM_BYTE: begin
                o_load_data = {{24{rd_shifted[7] & !i_ctrl.load_unsigned}}, rd_shifted[7:0]};
            end
            rv_pkg::MEM_HALF: begin
                o_load_data = {{16{rd_shifted[15] & !i_ctrl.load_unsigned}}, rd_shifted[15:0]};
            end
            default: begin
                o_load_data = rd_shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
    input  wire logic                         clk,
    input  wire logic [`RV_REG_ADDR_BITS-1:0] i_rs1_addr,
    input  wire logic [`RV_REG_ADDR_BITS-1:0] i_rs2_addr,
    input  wire logic [`RV_REG_ADDR_BITS-1:0] i_rd_addr,
    input  wire logic                         i_write,
    input  wire logic [`RV_XLEN-1:0]          i_rd_data,
    output logic [`RV_XLEN-1:0]               o_rs1_data,
    output logic [`RV_XLEN-1:0]               o_rs2_data
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:31];

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

    always_ff @(posedge clk) begin
        if (i_write && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

endmodule

`default_nettype wire

// File: source/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_alu (
    input  wire rv_pkg::alu_op_e     i_op,
    input  wire rv_pkg::branch_e     i_branch,
    input  wire logic [`RV_XLEN-1:0] i_a,
    input  wire logic [`RV_XLEN-1:0] i_b,
    output logic [`RV_XLEN-1:0]      o_result,
    output logic                     o_branch_taken
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    logic       equal;

    assign shamt       = i_b[4:0];
    assign lt_signed   = ($signed(i_a) < $signed(i_b));
    assign lt_unsigned = (i_a < i_b);
    assign equal       = (i_a == i_b);

    always_comb begin
        case (i_op)
            rv_pkg::ALU_ADD:    o_result = i_a + i_b;
            rv_pkg::ALU_SUB:    o_result = i_a - i_b;
            rv_pkg::ALU_AND:    o_result = i_a & i_b;
            rv_pkg::ALU_OR:     o_result = i_a | i_b;
            rv_pkg::ALU_XOR:    o_result = i_a ^ i_b;
            rv_pkg::ALU_SLL:    o_result = i_a << shamt;
            rv_pkg::ALU_SRL:    o_result = i_a >> shamt;
            rv_pkg::ALU_SRA:    o_result = $signed(i_a) >>> shamt;
            rv_pkg::ALU_SLT:    o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            rv_pkg::ALU_SLTU:   o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            rv_pkg::ALU_PASS_B: o_result = i_b;
            default:            o_result = i_a + i_b;
        endcase
    end

    // branch condition on rs1 and rs2
    always_comb begin
        case (i_branch)
            rv_pkg::BR_EQ:  o_branch_taken = equal;
            rv_pkg::BR_NE:  o_branch_taken = !equal;
            rv_pkg::BR_LT:  o_branch_taken = lt_signed;
            rv_pkg::BR_GE:  o_branch_taken = !lt_signed;
            rv_pkg::BR_LTU: o_branch_taken = lt_unsigned;
            rv_pkg::BR_GEU: o_branch_taken = !lt_unsigned;
            default:        o_branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decoder (
    input  wire logic [`RV_XLEN-1:0] i_inst,
    output rv_pkg::ctrl_t            o_ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_std;
    logic       funct7_alt;

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    // shared by register and immediate arithmetic
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_sel = rv_pkg::ALU_SLL;
            3'b010:  alu_sel = rv_pkg::ALU_SLT;
            3'b011:  alu_sel = rv_pkg::ALU_SLTU;
            3'b100:  alu_sel = rv_pkg::ALU_XOR;
            3'b101:  alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_sel = rv_pkg::ALU_OR;
            default: alu_sel = rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode     = i_inst[6:0];
    assign funct3     = i_inst[14:12];
    assign funct7_std = (i_inst[31:25] == 7'b0000000);
    assign funct7_alt = (i_inst[31:25] == 7'b0100000);

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    always_comb begin
        // default is a no-op: no write, no memory access, no jump
        o_ctrl          = '0;
        o_ctrl.alu_op   = rv_pkg::ALU_ADD;
        o_ctrl.branch   = rv_pkg::BR_NONE;
        o_ctrl.mem_size = rv_pkg::MEM_WORD;
        o_ctrl.rd       = i_inst[11:7];
        o_ctrl.rs1      = i_inst[19:15];
        o_ctrl.rs2      = i_inst[24:20];
        o_ctrl.imm      = imm_i;

        case (opcode)
            rv_pkg::OPCODE_LUI: begin
                o_ctrl.alu_op    = rv_pkg::ALU_PASS_B;
                o_ctrl.b_is_imm  = 1'b1;
                o_ctrl.imm       = imm_u;
                o_ctrl.reg_write = 1'b1;
            end
            rv_pkg::OPCODE_AUIPC: begin
                o_ctrl.a_is_pc   = 1'b1;
                o_ctrl.b_is_imm  = 1'b1;
                o_ctrl.imm       = imm_u;
                o_ctrl.reg_write = 1'b1;
            end
            rv_pkg::OPCODE_JAL: begin
                o_ctrl.imm       = imm_j;
                o_ctrl.jal       = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            rv_pkg::OPCODE_JALR: begin
                if (funct3 == 3'b000) begin
                    o_ctrl.b_is_imm  = 1'b1;
                    o_ctrl.jalr      = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                end
            end
            rv_pkg::OPCODE_BRANCH: begin
                o_ctrl.imm = imm_b;
                case (funct3)
                    3'b000:  o_ctrl.branch = rv_pkg::BR_EQ;
                    3'b001:  o_ctrl.branch = rv_pkg::BR_NE;
                    3'b100:  o_ctrl.branch = rv_pkg::BR_LT;
                    3'b101:  o_ctrl.branch = rv_pkg::BR_GE;
                    3'b110:  o_ctrl.branch = rv_pkg::BR_LTU;
                    3'b111:  o_ctrl.branch = rv_pkg::BR_GEU;
                    default: o_ctrl.branch = rv_pkg::BR_NONE;
                endcase
            end
            rv_pkg::OPCODE_LOAD: begin
                // lb lh lw lbu lhu only
                if (funct3[1:0] != 2'b11 && !(funct3[2] && funct3[1])) begin
                    o_ctrl.b_is_imm      = 1'b1;
                    o_ctrl.load          = 1'b1;
                    o_ctrl.reg_write     = 1'b1;
                    o_ctrl.mem_size      = rv_pkg::mem_size_e'(funct3[1:0]);
                    o_ctrl.load_unsigned = funct3[2];
                end
            end
            rv_pkg::OPCODE_STORE: begin
                if (!funct3[2] && funct3[1:0] != 2'b11) begin
                    o_ctrl.b_is_imm = 1'b1;
                    o_ctrl.imm      = imm_s;
                    o_ctrl.store    = 1'b1;
                    o_ctrl.mem_size = rv_pkg::mem_size_e'(funct3[1:0]);
                end
            end
            rv_pkg::OPCODE_OP_IMM: begin
                // shifts carry funct7 in the upper immediate bits
                if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7_std
                        || (funct3 == 3'b101 && funct7_alt)) begin
                    o_ctrl.b_is_imm  = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.alu_op    = alu_sel(funct3, funct7_alt && funct3 == 3'b101);
                end
            end
            rv_pkg::OPCODE_OP: begin
                if (funct7_std || (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.alu_op    = alu_sel(funct3, funct7_alt);
                end
            end
            default: begin
                // fence, ecall, ebreak and anything unknown fall through as no-ops
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_e;

    // encoding follows funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    // one decoded instruction
    typedef struct packed {
        alu_op_e                      alu_op;
        logic                         a_is_pc;
        logic                         b_is_imm;
        logic                         reg_write;
        logic                         load;
        logic                         store;
        mem_size_e                    mem_size;
        logic                         load_unsigned;
        branch_e                      branch;
        logic                         jal;
        logic                         jalr;
        logic [`RV_REG_ADDR_BITS-1:0] rd;
        logic [`RV_REG_ADDR_BITS-1:0] rs1;
        logic [`RV_REG_ADDR_BITS-1:0] rs2;
        logic [`RV_XLEN-1:0]          imm;
    } ctrl_t;

    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } uart_tx_t;

endpackage

`default_nettype wire

// File: source/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and address width
`define RV_XLEN 32

// register index width, 32 architectural registers
`define RV_REG_ADDR_BITS 5

// data memory geometry, word addressed
`define RV_DMEM_WORDS 1024
`define RV_DMEM_ADDR_BITS 10

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// byte stores here leave the core on the transmit port
`define RV_UART_TX_ADDR 32'h0001_0000

`endif
